//--- logic/sample_sound_pkg.sv
package sample_sound_pkg;

	// ========================================
	// Channels and widths
	// ========================================

	typedef enum logic [1:0] {
		CH_WALK = 2'd0,
		CH_JUMP = 2'd1,
		CH_LAND = 2'd2,
		CH_FALL = 2'd3
	} sample_chan_e;

	localparam int SAMPLE_W   = 16;
	localparam int ROM_ADDR_W = 16;
	localparam int VOL_W      = 4;
	localparam int MIX_W      = 19;
	localparam int N_CHAN     = 4;
	localparam int SLOT_W     = 4;

	// 12.288 MHz / 1115, about 11.02 kHz
	localparam int RATE_DIV   = 1115;
	localparam int RATE_CNT_W = $clog2(RATE_DIV);

	// Output clamp limits
	localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7FFF;
	localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 16'sh8000;

	// ========================================
	// Sample regions in the wave ROM
	// ========================================

	localparam logic [ROM_ADDR_W-1:0] CHAN_BASE [N_CHAN] = '{16'h0000, 16'h3000, 16'h5000, 16'h7000};
	localparam logic [ROM_ADDR_W-1:0] CHAN_LEN [N_CHAN] = '{16'h0800, 16'h2000, 16'h2000, 16'h5000};
	localparam logic CHAN_STOP [N_CHAN] = '{1'b0, 1'b0, 1'b0, 1'b1};

	// Walk start bank, one step per trigger
	localparam int WALK_STEPS = 7;
	localparam int WALK_IDX_W = 3;
	localparam int BANK_W     = 2;
	localparam logic [ROM_ADDR_W-1:0] WALK_BANK_SIZE = 16'h0800;
	localparam logic [BANK_W-1:0] WALK_BANKS [WALK_STEPS] = '{2'd1, 2'd2, 2'd1, 2'd2, 2'd0, 2'd1, 2'd0};

	function automatic logic [ROM_ADDR_W-1:0] chan_base(sample_chan_e ch);
		return CHAN_BASE[ch];
	endfunction

	function automatic logic [ROM_ADDR_W-1:0] chan_len(sample_chan_e ch);
		return CHAN_LEN[ch];
	endfunction

	function automatic logic chan_stops(sample_chan_e ch);
		return CHAN_STOP[ch];
	endfunction

	function automatic logic [ROM_ADDR_W-1:0] walk_base(logic [WALK_IDX_W-1:0] idx);
		return ROM_ADDR_W'(WALK_BANKS[idx]) * WALK_BANK_SIZE;
	endfunction

endpackage

//--- logic/sample_bus_timing.sv
`timescale 1ns/1ps

module sample_bus_timing (
	input  logic W_CLK_12288M,
	input  logic W_RESETn,
	input  logic [sample_sound_pkg::N_CHAN-1:0][sample_sound_pkg::ROM_ADDR_W-1:0] chan_addr,
	input  logic [sample_sound_pkg::SAMPLE_W-1:0] wav_rom_data,
	output logic [sample_sound_pkg::ROM_ADDR_W-1:0] wav_rom_addr,
	output logic [sample_sound_pkg::SAMPLE_W-1:0] rom_sample,
	output logic [sample_sound_pkg::N_CHAN-1:0] fetch_strobe,
	output logic step_tick
);
	import sample_sound_pkg::*;

	logic [SLOT_W-1:0] slot;
	logic [RATE_CNT_W-1:0] rate_cnt;
	logic [1:0] slot_chan;
	logic addr_slot;
	logic data_slot;

	// Slots 0..7 carry the channels, address then data
	assign slot_chan = slot[2:1];
	assign addr_slot = ~slot[SLOT_W-1] & ~slot[0];
	assign data_slot = ~slot[SLOT_W-1] & slot[0];

	// ========================================
	// Slot frame
	// ========================================

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			slot         <= '0;
			wav_rom_addr <= '0;
			fetch_strobe <= '0;
		end else begin
			slot         <= slot + 1'b1;
			fetch_strobe <= '0;
			if (addr_slot)
				wav_rom_addr <= chan_addr[slot_chan];
			if (data_slot)
				fetch_strobe[slot_chan] <= 1'b1;
		end
	end

	// Word for the channel whose strobe follows
	always_ff @(posedge W_CLK_12288M) begin
		if (data_slot)
			rom_sample <= wav_rom_data;
	end

	// ========================================
	// Sample rate divider
	// ========================================

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			rate_cnt  <= '0;
			step_tick <= 1'b0;
		end else if (rate_cnt == RATE_CNT_W'(RATE_DIV - 1)) begin
			rate_cnt  <= '0;
			step_tick <= 1'b1;
		end else begin
			rate_cnt  <= rate_cnt + 1'b1;
			step_tick <= 1'b0;
		end
	end

endmodule

//--- logic/sample_channel.sv
`timescale 1ns/1ps

module sample_channel #(
	parameter sample_sound_pkg::sample_chan_e chan = sample_sound_pkg::CH_WALK
) (
	input  logic W_CLK_12288M,
	input  logic W_RESETn,
	input  logic trig,
	input  logic [sample_sound_pkg::VOL_W-1:0] vol,
	input  logic step_tick,
	input  logic fetch_strobe,
	input  logic [sample_sound_pkg::SAMPLE_W-1:0] rom_sample,
	output logic [sample_sound_pkg::ROM_ADDR_W-1:0] chan_addr,
	output logic signed [sample_sound_pkg::SAMPLE_W-1:0] chan_out
);
	import sample_sound_pkg::*;

	logic trig_d;
	logic trig_rise;
	logic stop_req;
	logic playing;
	logic [ROM_ADDR_W-1:0] remaining;
	logic [ROM_ADDR_W-1:0] start_addr;

	// Volume 0..15 maps to gain 1/16..16/16
	logic [VOL_W:0] vol_gain;
	logic signed [SAMPLE_W+VOL_W+1:0] product;
	logic signed [SAMPLE_W-1:0] scaled;

	assign trig_rise = trig & ~trig_d;

	// ========================================
	// Start address
	// ========================================

	generate
		if (chan == CH_WALK) begin : g_walk
			logic [WALK_IDX_W-1:0] bank_idx;

			assign start_addr = walk_base(bank_idx);

			// Next bank is picked on every new trigger
			always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
				if (!W_RESETn) begin
					bank_idx <= '0;
				end else if (trig_rise) begin
					if (bank_idx == WALK_IDX_W'(WALK_STEPS - 1))
						bank_idx <= '0;
					else
						bank_idx <= bank_idx + 1'b1;
				end
			end
		end else begin : g_fixed
			assign start_addr = chan_base(chan);
		end
	endgenerate

	// Release cuts the sound short on the fall channel only
	generate
		if (chan_stops(chan)) begin : g_stop
			assign stop_req = ~trig & trig_d;
		end else begin : g_no_stop
			assign stop_req = 1'b0;
		end
	endgenerate

	// ========================================
	// Playback state and address stepping
	// ========================================

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			trig_d    <= 1'b0;
			playing   <= 1'b0;
			chan_addr <= '0;
			remaining <= '0;
		end else begin
			trig_d <= trig;
			if (trig_rise) begin
				// A retrigger restarts from the top
				playing   <= 1'b1;
				chan_addr <= start_addr;
				remaining <= chan_len(chan);
			end else if (stop_req) begin
				playing <= 1'b0;
			end else if (playing && step_tick) begin
				chan_addr <= chan_addr + 1'b1;
				remaining <= remaining - 1'b1;
				if (remaining == ROM_ADDR_W'(1))
					playing <= 1'b0;
			end
		end
	end

	// ========================================
	// Volume scaling
	// ========================================

	assign vol_gain = vol + 1'b1;
	assign product  = $signed(rom_sample) * $signed({1'b0, vol_gain});

	// Arithmetic shift by 4, result always fits 16 bits
	assign scaled = product[SAMPLE_W+VOL_W-1:VOL_W];

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			chan_out <= '0;
		end else if (fetch_strobe) begin
			if (playing)
				chan_out <= scaled;
			else
				chan_out <= '0;
		end
	end

endmodule

//--- logic/sound_mixer.sv
`timescale 1ns/1ps

module sound_mixer (
	input  logic W_CLK_12288M,
	input  logic W_RESETn,
	input  logic signed [sample_sound_pkg::N_CHAN-1:0][sample_sound_pkg::SAMPLE_W-1:0] chan_out,
	input  logic signed [sample_sound_pkg::SAMPLE_W-1:0] digital_sound,
	output logic signed [sample_sound_pkg::SAMPLE_W-1:0] sound_out
);
	import sample_sound_pkg::*;

	logic signed [MIX_W-1:0] mix_sum;

	// ========================================
	// Five-term sum
	// ========================================

	always_comb begin
		mix_sum = MIX_W'(digital_sound);
		for (int i = 0; i < N_CHAN; i++) begin
			mix_sum = mix_sum + MIX_W'($signed(chan_out[i]));
		end
	end

	// ========================================
	// Limiter
	// ========================================

	always_ff @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn) begin
			sound_out <= '0;
		end else if (mix_sum > SAMPLE_MAX) begin
			// Positive clip
			sound_out <= SAMPLE_MAX;
		end else if (mix_sum < SAMPLE_MIN) begin
			// Negative clip
			sound_out <= SAMPLE_MIN;
		end else begin
			sound_out <= mix_sum[SAMPLE_W-1:0];
		end
	end

endmodule

//--- logic/sample_sound_top.sv
`timescale 1ns/1ps

module sample_sound_top (
	input  logic W_CLK_12288M,
	input  logic W_RESETn,
	input  logic walk,
	input  logic jump,
	input  logic land,
	input  logic fall,
	input  logic [sample_sound_pkg::VOL_W-1:0] vol,
	input  logic signed [sample_sound_pkg::SAMPLE_W-1:0] digital_sound,
	input  logic [sample_sound_pkg::SAMPLE_W-1:0] wav_rom_data,
	output logic [sample_sound_pkg::ROM_ADDR_W-1:0] wav_rom_addr,
	output logic signed [sample_sound_pkg::SAMPLE_W-1:0] sound_out
);
	import sample_sound_pkg::*;

	logic [N_CHAN-1:0][ROM_ADDR_W-1:0] chan_addr;
	logic signed [N_CHAN-1:0][SAMPLE_W-1:0] chan_out;
	logic [SAMPLE_W-1:0] rom_sample;
	logic [N_CHAN-1:0] fetch_strobe;
	logic step_tick;

	// ========================================
	// Shared wave ROM port
	// ========================================

	sample_bus_timing u_bus (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.chan_addr    (chan_addr),
		.wav_rom_data (wav_rom_data),
		.wav_rom_addr (wav_rom_addr),
		.rom_sample   (rom_sample),
		.fetch_strobe (fetch_strobe),
		.step_tick    (step_tick)
	);

	// ========================================
	// Sample channels
	// ========================================

	sample_channel #(.chan(CH_WALK)) u_walk (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.trig         (walk),
		.vol          (vol),
		.step_tick    (step_tick),
		.fetch_strobe (fetch_strobe[CH_WALK]),
		.rom_sample   (rom_sample),
		.chan_addr    (chan_addr[CH_WALK]),
		.chan_out     (chan_out[CH_WALK])
	);

	sample_channel #(.chan(CH_JUMP)) u_jump (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.trig         (jump),
		.vol          (vol),
		.step_tick    (step_tick),
		.fetch_strobe (fetch_strobe[CH_JUMP]),
		.rom_sample   (rom_sample),
		.chan_addr    (chan_addr[CH_JUMP]),
		.chan_out     (chan_out[CH_JUMP])
	);

	sample_channel #(.chan(CH_LAND)) u_land (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.trig         (land),
		.vol          (vol),
		.step_tick    (step_tick),
		.fetch_strobe (fetch_strobe[CH_LAND]),
		.rom_sample   (rom_sample),
		.chan_addr    (chan_addr[CH_LAND]),
		.chan_out     (chan_out[CH_LAND])
	);

	sample_channel #(.chan(CH_FALL)) u_fall (
		.W_CLK_12288M (W_CLK_12288M),
		.W_RESETn     (W_RESETn),
		.trig         (fall),
		.vol          (vol),
		.step_tick    (step_tick),
		.fetch_strobe (fetch_strobe[CH_FALL]),
		.rom_sample   (rom_sample),
		.chan_addr    (chan_addr[CH_FALL]),
		.chan_out     (chan_out[CH_FALL])
	);

	// Samples plus digital sound
	sound_mixer u_mixer (
		.W_CLK_12288M  (W_CLK_12288M),
		.W_RESETn      (W_RESETn),
		.chan_out      (chan_out),
		.digital_sound (digital_sound),
		.sound_out     (sound_out)
	);

endmodule

//--- testbench/tb_sample_sound.sv
`timescale 1ns/1ps

module tb_sample_sound;

	localparam int CLK_NS = 40;
	localparam int RATE_CLKS = 1115;
	// The walk run of 0x800 steps dominates the run time
	// Other tests take a few sample periods
	localparam int RUN_CLKS = 16'h0801 * RATE_CLKS + 10 * RATE_CLKS + 300000;

	localparam logic [15:0] JUMP_START = 16'h3000;
	localparam logic [15:0] LAND_START = 16'h5000;
	localparam logic [15:0] FALL_START = 16'h7000;
	// Bank sequence 1 2 1 2 0 1 0 in 0x800 words that wraps to 1
	localparam logic [15:0] WALK_START [8] = '{16'h0800, 16'h1000, 16'h0800, 16'h1000,
		16'h0000, 16'h0800, 16'h0000, 16'h0800};

	logic W_CLK_12288M;
	logic W_RESETn;
	logic walk;
	logic jump;
	logic land;
	logic fall;
	logic [3:0] vol;
	logic signed [15:0] digital_sound;
	logic [15:0] wav_rom_data;
	logic [15:0] wav_rom_addr;
	logic signed [15:0] sound_out;

	int cyc;
	int errors;
	int checks;
	logic [31:0] lcg_state;

	// ========================================
	// Reference model
	// ========================================

	function automatic logic [15:0] rom_word(input logic [15:0] addr);
		return addr ^ 16'h5A5A;
	endfunction

	// Word times (vol+1)/16 rounded down
	function automatic int scaled_word(input logic [15:0] addr, input logic [3:0] v);
		int s;
		s = $signed(rom_word(addr));
		return (s * (int'(v) + 1)) >>> 4;
	endfunction

	function automatic int all_four(input logic [3:0] v);
		return scaled_word(WALK_START[0], v) + scaled_word(JUMP_START, v)
			+ scaled_word(LAND_START, v) + scaled_word(FALL_START, v);
	endfunction

	function automatic logic [15:0] mixed(input int sum);
		if (sum > 32767)
			return 16'h7FFF;
		if (sum < -32768)
			return 16'h8000;
		return 16'(sum);
	endfunction

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	assign wav_rom_data = rom_word(wav_rom_addr);

	sample_sound_top dut (
		.W_CLK_12288M  (W_CLK_12288M),
		.W_RESETn      (W_RESETn),
		.walk          (walk),
		.jump          (jump),
		.land          (land),
		.fall          (fall),
		.vol           (vol),
		.digital_sound (digital_sound),
		.wav_rom_data  (wav_rom_data),
		.wav_rom_addr  (wav_rom_addr),
		.sound_out     (sound_out)
	);

	initial begin
		W_CLK_12288M = 1'b0;
		forever #(CLK_NS / 2) W_CLK_12288M = ~W_CLK_12288M;
	end

	// Cycles since reset, so cyc % 16 is the DUT slot after each edge
	always @(posedge W_CLK_12288M or negedge W_RESETn) begin
		if (!W_RESETn)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// ========================================
	// Bus helpers
	// ========================================

	task automatic wait_edge();
		@(posedge W_CLK_12288M);
		#1;
	endtask

	task automatic wait_slot(input int s);
		wait_edge();
		while (cyc % 16 != s)
			wait_edge();
	endtask

	// Returns just after the edge where a sample step lands
	task automatic wait_step();
		wait_edge();
		while (cyc % RATE_CLKS != 1)
			wait_edge();
	endtask

	task automatic drive_inputs(input logic [3:0] v, input logic [15:0] d);
		@(posedge W_CLK_12288M);
		vol <= v;
		digital_sound <= d;
		#1;
	endtask

	task automatic set_triggers(input logic [3:0] t);
		@(posedge W_CLK_12288M);
		{fall, land, jump, walk} <= t;
		#1;
	endtask

	task automatic apply_reset();
		@(posedge W_CLK_12288M);
		W_RESETn <= 1'b0;
		{fall, land, jump, walk} <= 4'b0000;
		vol <= 4'd0;
		digital_sound <= 16'h0000;
		repeat (16) @(posedge W_CLK_12288M);
		W_RESETn <= 1'b1;
		#1;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("[FAIL] %s expected %h got %h at cycle %0d", name, exp, got, cyc);
		end
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic test_reset();
		apply_reset();
		check_value("wav_rom_addr", wav_rom_addr, 16'h0000);
		check_value("sound_out", sound_out, 16'h0000);
		repeat (64) begin
			wait_edge();
			check_value("sound_out", sound_out, 16'h0000);
		end
	endtask

	task automatic test_jump_mix();
		logic [15:0] addr;
		logic [3:0] v;
		logic [15:0] d;
		apply_reset();
		wait_step();
		set_triggers(4'b0010);
		for (int ph = 0; ph < 2; ph++) begin
			addr = JUMP_START + 16'(ph);
			if (ph == 1)
				wait_step();
			repeat (6) begin
				v = 4'(lcg_next());
				d = lcg_next();
				drive_inputs(v, d);
				wait_slot(3);
				check_value("wav_rom_addr", wav_rom_addr, addr);
				wait_slot(12);
				check_value("sound_out", sound_out, mixed(scaled_word(addr, v) + $signed(d)));
			end
		end
	endtask

	task automatic test_walk_banks();
		logic [3:0] v;
		apply_reset();
		wait_step();
		for (int i = 0; i < 8; i++) begin
			set_triggers(4'b0001);
			wait_edge();
			wait_slot(1);
			check_value("wav_rom_addr", wav_rom_addr, WALK_START[i]);
			set_triggers(4'b0000);
		end
		v = 4'(lcg_next());
		drive_inputs(v, 16'h0000);
		// Last word of the run comes one step before the end
		repeat (16'h07FF) wait_step();
		wait_slot(1);
		check_value("wav_rom_addr", wav_rom_addr, 16'h0FFF);
		wait_slot(12);
		check_value("sound_out", sound_out, mixed(scaled_word(16'h0FFF, v)));
		wait_step();
		wait_slot(12);
		wait_slot(12);
		repeat (16) begin
			wait_edge();
			check_value("sound_out", sound_out, 16'h0000);
		end
	endtask

	task automatic test_fall_release();
		logic [3:0] v;
		logic [15:0] d;
		apply_reset();
		v = 4'(lcg_next());
		d = lcg_next();
		drive_inputs(v, d);
		wait_step();
		set_triggers(4'b1100);
		wait_edge();
		wait_slot(5);
		check_value("wav_rom_addr", wav_rom_addr, LAND_START);
		wait_slot(7);
		check_value("wav_rom_addr", wav_rom_addr, FALL_START);
		wait_slot(12);
		check_value("sound_out", sound_out,
			mixed(scaled_word(LAND_START, v) + scaled_word(FALL_START, v) + $signed(d)));
		set_triggers(4'b0000);
		// Fall output is gone one frame plus two clocks after release
		repeat (17) wait_edge();
		repeat (16) begin
			wait_edge();
			check_value("sound_out", sound_out, mixed(scaled_word(LAND_START, v) + $signed(d)));
		end
		// Land carries on to its next word
		wait_step();
		wait_slot(5);
		check_value("wav_rom_addr", wav_rom_addr, LAND_START + 16'h0001);
		wait_slot(12);
		check_value("sound_out", sound_out,
			mixed(scaled_word(LAND_START + 16'h0001, v) + $signed(d)));
	endtask

	task automatic test_saturation();
		apply_reset();
		drive_inputs(4'd0, 16'h8000);
		wait_slot(12);
		wait_slot(12);
		check_value("sound_out", sound_out, mixed(-32768));
		wait_step();
		drive_inputs(4'd15, 16'h7F00);
		set_triggers(4'b1111);
		wait_slot(12);
		wait_slot(12);
		check_value("sound_out", sound_out, mixed(all_four(4'd15) + 'h7F00));
		drive_inputs(4'd0, 16'h0000);
		wait_slot(12);
		wait_slot(12);
		check_value("sound_out", sound_out, mixed(all_four(4'd0)));
	endtask

	// ========================================
	// Run control
	// ========================================

	initial begin
		W_RESETn = 1'b0;
		walk = 1'b0;
		jump = 1'b0;
		land = 1'b0;
		fall = 1'b0;
		vol = 4'd0;
		digital_sound = 16'h0000;
		errors = 0;
		checks = 0;
		lcg_state = 32'hfb31736c;
		test_reset();
		test_jump_mix();
		test_walk_banks();
		test_fall_release();
		test_saturation();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(RUN_CLKS * CLK_NS);
		$display("Timeout: the tests did not finish within %0d clock cycles", RUN_CLKS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- src.f
logic/sample_sound_pkg.sv
logic/sample_bus_timing.sv
logic/sample_channel.sv
logic/sound_mixer.sv
logic/sample_sound_top.sv
testbench/tb_sample_sound.sv
